// ==== mem_system.f ====
+incdir+design
design/cache_pkg.sv
design/cache_ifs.sv
design/cache_way.sv
design/banked_memory.sv
design/cache_controller.sv
design/mem_system.sv
bench/mem_system_asserts.sv
bench/mem_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   --top-module mem_system_tb \
   -Mdir "$OBJ" -o mem_system_sim \
   -f mem_system.f
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$OBJ/mem_system_sim" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

# the log decides the result
if grep -q "sim failed" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi
if [ $runStatus -ne 0 ]; then
   echo "simulation exited with status $runStatus"
   exit 1
fi
exit 0

// ==== bench/mem_system_tb.sv ====
/*
 * Memory system testbench.
 * Directed table then LFSR random accesses, checked against a shadow memory and a way model.
 */
`include "mem_system_cfg.svh"

`timescale 1ns/10ps

`default_nettype none

module mem_system_tb;

   localparam int NumDirected   = 11;
   localparam int NumRandom     = 200;
   localparam int TimeoutCycles = 20 * (NumDirected + NumRandom) * 20;

   typedef struct packed {
      logic             isWrite;
      cache_pkg::addr_t addr;
      cache_pkg::word_t data;
      logic             expHit;
   } stimEntry_t;

   logic             clk = 1'b0;
   logic             rstN;
   cache_pkg::addr_t addr;
   cache_pkg::word_t dataIn;
   logic             rd;
   logic             wr;
   cache_pkg::word_t dataOut;
   logic             done;
   logic             stall;
   logic             cacheHit;

   stimEntry_t       stimTable [NumDirected];
   // expected memory contents with one entry per word address
   cache_pkg::word_t shadowMem [2 ** (`ADDR_W - 1)];
   // tags and valid bits of both ways plus the victim bit
   logic             modelValid [2][2 ** `INDEX_W];
   cache_pkg::tag_t  modelTag [2][2 ** `INDEX_W];
   logic             modelVictim;
   logic [15:0]      lfsrState;
   int               cycleCount = 0;

   mem_system mem_system_inst (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (addr),
      .dataIn   (dataIn),
      .rd       (rd),
      .wr       (wr),
      .dataOut  (dataOut),
      .done     (done),
      .stall    (stall),
      .cacheHit (cacheHit)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles) begin
         failRun($sformatf("the run timed out after %0d cycles", cycleCount));
      end
   end

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "run stopped on the first failure");
   endtask

   // ####################################################################
   // stimulus helpers
   // ####################################################################

   // fibonacci LFSR with taps at x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one LFSR step per bit taken
   task automatic drawBits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = lfsrNext(lfsrState);
         val = {val[14:0], lfsrState[0]};
      end
   endtask

   function automatic cache_pkg::addr_t composeAddr(input cache_pkg::tag_t t,
                                                    input cache_pkg::index_t i,
                                                    input cache_pkg::offset_t o);
      return {t, i, o};
   endfunction

   // small tag set so sets keep getting evicted
   function automatic cache_pkg::tag_t pickTag(input logic [1:0] sel);
      case (sel)
         2'd0:    return 5'h01;
         2'd1:    return 5'h03;
         2'd2:    return 5'h0a;
         default: return 5'h1d;
      endcase
   endfunction

   function automatic cache_pkg::index_t pickIndex(input logic [1:0] sel);
      case (sel)
         2'd0:    return 8'h20;
         2'd1:    return 8'h21;
         2'd2:    return 8'h9c;
         default: return 8'hff;
      endcase
   endfunction

   // way choice prefers the hit way, then the first invalid way, then the victim
   // victim flips after every access
   task automatic updateModel(input cache_pkg::addr_t a, output logic hit);
      cache_pkg::tag_t   t;
      cache_pkg::index_t i;
      logic              w;
      t = a[`ADDR_W-1 -: `TAG_W];
      i = a[`OFFSET_W +: `INDEX_W];
      hit = (modelValid[0][i] && (modelTag[0][i] == t)) ||
            (modelValid[1][i] && (modelTag[1][i] == t));
      if (!hit) begin
         if (!modelValid[0][i]) w = 1'b0;
         else if (!modelValid[1][i]) w = 1'b1;
         else w = modelVictim;
         modelValid[w][i] = 1'b1;
         modelTag[w][i]   = t;
      end
      modelVictim = ~modelVictim;
   endtask

   // one request held until done before going back to idle
   task automatic runAccess(input logic isWrite, input cache_pkg::addr_t a,
                            input cache_pkg::word_t d, input logic expHit);
      int               waitCycles;
      cache_pkg::word_t expData;
      waitCycles = 0;
      expData    = shadowMem[a[`ADDR_W-1:1]];
      @(posedge clk);
      #2;
      // controller sits in idle between requests
      assert (!done && !stall && !cacheHit) else failRun($sformatf(
         "error at time %0t: done, stall or cacheHit high in idle before access to %h",
         $time, a));
      addr   = a;
      dataIn = d;
      rd     = !isWrite;
      wr     = isWrite;
      while (!done) begin
         @(posedge clk);
         #2;
         waitCycles++;
         if (!done) begin
            assert (stall) else failRun($sformatf(
               "error at time %0t: stall low in cycle %0d of access to %h",
               $time, waitCycles, a));
            assert (!cacheHit) else failRun($sformatf(
               "error at time %0t: cacheHit high before done in cycle %0d of access to %h",
               $time, waitCycles, a));
         end
      end
      assert (!stall) else failRun($sformatf(
         "error at time %0t: stall high in the done cycle of access to %h", $time, a));
      assert (cacheHit == expHit) else failRun($sformatf(
         "error at time %0t: %s of %h gave cacheHit %b, expected %b",
         $time, isWrite ? "write" : "read", a, cacheHit, expHit));
      if (expHit) begin
         assert (waitCycles == 2) else failRun($sformatf(
            "error at time %0t: hit on %h took %0d cycles, expected 2",
            $time, a, waitCycles));
      end
      if (isWrite) begin
         shadowMem[a[`ADDR_W-1:1]] = d;
      end else begin
         assert (dataOut == expData) else failRun($sformatf(
            "error at time %0t: read of %h returned %h, expected %h",
            $time, a, dataOut, expData));
      end
      rd = 1'b0;
      wr = 1'b0;
   endtask

   // ####################################################################
   // test sequence
   // ####################################################################

   initial begin
      logic [15:0]      opBits;
      logic [15:0]      tagBits;
      logic [15:0]      indexBits;
      logic [15:0]      wordBits;
      logic [15:0]      randData;
      cache_pkg::addr_t randAddr;
      logic             expHit;
      rstN        = 1'b0;
      addr        = '0;
      dataIn      = '0;
      rd          = 1'b0;
      wr          = 1'b0;
      lfsrState   = 16'd56;
      modelVictim = 1'b0;
      for (int w = 0; w < 2 ** (`ADDR_W - 1); w++) begin
         shadowMem[w] = '0;
      end
      for (int s = 0; s < 2 ** `INDEX_W; s++) begin
         modelValid[0][s] = 1'b0;
         modelValid[1][s] = 1'b0;
      end

      // tags 1, 2 and 3 compete for the two ways of set 0x20
      stimTable[0]  = '{1'b1, composeAddr(5'h01, 8'h20, 3'd2), 16'hbeef, 1'b0};
      stimTable[1]  = '{1'b0, composeAddr(5'h01, 8'h20, 3'd2), 16'h0000, 1'b1};
      stimTable[2]  = '{1'b1, composeAddr(5'h02, 8'h20, 3'd4), 16'h1234, 1'b0};
      stimTable[3]  = '{1'b0, composeAddr(5'h01, 8'h20, 3'd2), 16'h0000, 1'b1};
      stimTable[4]  = '{1'b0, composeAddr(5'h02, 8'h20, 3'd4), 16'h0000, 1'b1};
      // victim is way1 so the dirty tag 2 line goes back to memory
      stimTable[5]  = '{1'b1, composeAddr(5'h03, 8'h20, 3'd0), 16'h5a5a, 1'b0};
      stimTable[6]  = '{1'b0, composeAddr(5'h03, 8'h20, 3'd0), 16'h0000, 1'b1};
      stimTable[7]  = '{1'b0, composeAddr(5'h02, 8'h20, 3'd4), 16'h0000, 1'b0};
      stimTable[8]  = '{1'b0, composeAddr(5'h01, 8'h20, 3'd2), 16'h0000, 1'b1};
      stimTable[9]  = '{1'b0, composeAddr(5'h03, 8'h20, 3'd0), 16'h0000, 1'b0};
      stimTable[10] = '{1'b0, composeAddr(5'h01, 8'h20, 3'd6), 16'h0000, 1'b1};

      repeat (8) @(posedge clk);
      #2;
      rstN = 1'b1;
      assert (!done && !stall && !cacheHit) else failRun($sformatf(
         "error at time %0t: done, stall or cacheHit high after reset", $time));

      for (int n = 0; n < NumDirected; n++) begin
         updateModel(stimTable[n].addr, expHit);
         runAccess(stimTable[n].isWrite, stimTable[n].addr, stimTable[n].data,
                   stimTable[n].expHit);
      end

      // random phase with hit flags taken from the way model
      for (int n = 0; n < NumRandom; n++) begin
         drawBits(1, opBits);
         drawBits(2, tagBits);
         drawBits(2, indexBits);
         drawBits(2, wordBits);
         drawBits(16, randData);
         randAddr = composeAddr(pickTag(tagBits[1:0]), pickIndex(indexBits[1:0]),
                                {wordBits[1:0], 1'b0});
         updateModel(randAddr, expHit);
         runAccess(opBits[0], randAddr, randData, expHit);
      end

      @(posedge clk);
      #2;
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/mem_system_asserts.sv ====
/*
 * Memory system protocol checks.
 * Bound to the top level, covers done, stall, cacheHit and read data.
 */
`timescale 1ns/10ps

`default_nettype none

module mem_system_asserts (
   input logic             clk,
   input logic             rstN,
   input logic             rd,
   input logic             wr,
   input logic             done,
   input logic             stall,
   input logic             cacheHit,
   input cache_pkg::word_t dataOut
);

   // request type, latched at the edge where the controller takes it
   logic readReq;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         readReq <= 1'b0;
      end else if (!stall) begin
         readReq <= rd && !wr;
      end
   end

   hitOnlyInDone: assert property (@(posedge clk) disable iff (!rstN) cacheHit |-> done)
      else $error("cacheHit high outside a done cycle");

   noStallInDone: assert property (@(posedge clk) disable iff (!rstN) done |-> !stall)
      else $error("stall high in a done cycle");

   // read data must be fully known when the read completes
   readDataKnown: assert property (@(posedge clk) disable iff (!rstN)
      (done && readReq) |-> !$isunknown(dataOut))
      else $error("dataOut has unknown bits at the end of a read");

endmodule

bind mem_system mem_system_asserts protocolChecks (
   .clk      (clk),
   .rstN     (rstN),
   .rd       (rd),
   .wr       (wr),
   .done     (done),
   .stall    (stall),
   .cacheHit (cacheHit),
   .dataOut  (dataOut)
);

`default_nettype wire

// ==== design/mem_system.sv ====
/*
 * Memory system top level.
 * Two-way write-back cache in front of a four-bank main memory.
 */
`timescale 1ns/10ps

`default_nettype none

module mem_system (
   input  logic               clk,
   input  logic               rstN,
   input  cache_pkg::addr_t   addr,
   input  cache_pkg::word_t   dataIn,
   input  logic               rd,
   input  logic               wr,
   output cache_pkg::word_t   dataOut,
   output logic               done,
   output logic               stall,
   output logic               cacheHit
);

   // one way bus per way, one memory bus
   wayIf way0If ();
   wayIf way1If ();
   memIf memBus ();

   cache_controller ctrl (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (addr),
      .dataIn   (dataIn),
      .rd       (rd),
      .wr       (wr),
      .dataOut  (dataOut),
      .done     (done),
      .stall    (stall),
      .cacheHit (cacheHit),
      .way0     (way0If.controller),
      .way1     (way1If.controller),
      .mem      (memBus.controller)
   );

   cache_way way0 (
      .clk  (clk),
      .rstN (rstN),
      .port (way0If.way)
   );

   cache_way way1 (
      .clk  (clk),
      .rstN (rstN),
      .port (way1If.way)
   );

   // backing store, seen by the controller only through its stall
   banked_memory mem (
      .clk  (clk),
      .rstN (rstN),
      .port (memBus.memory)
   );

endmodule

`default_nettype wire

// ==== design/cache_controller.sv ====
/*
 * Cache controller.
 * Lookup, dirty write-back, line fill, way choice and victim tracking.
 */
`include "mem_system_cfg.svh"

`timescale 1ns/10ps

`default_nettype none

module cache_controller (
   input  logic               clk,
   input  logic               rstN,
   input  cache_pkg::addr_t   addr,
   input  cache_pkg::word_t   dataIn,
   input  logic               rd,
   input  logic               wr,
   output cache_pkg::word_t   dataOut,
   output logic               done,
   output logic               stall,
   output logic               cacheHit,
   wayIf.controller           way0,
   wayIf.controller           way1,
   memIf.controller           mem
);

   // ####################################################################
   // request fields and way views
   // ####################################################################

   cache_pkg::ctrlState_e state, nextState, startState, lookupNext;
   cache_pkg::tag_t       reqTag, memTag, chosenTag;
   cache_pkg::index_t     reqIndex;
   cache_pkg::offset_t    reqOffset, memOffset, wayOffset;
   cache_pkg::word_t      wayData, chosenData;
   logic chosenWay, victimWay, victimNext, choice;
   logic chosenValid, chosenDirty, anyHit;
   logic memRd, memWr, wayWrite, wayCompare;

   // byte offset of word n in the line
   function automatic cache_pkg::offset_t lineOffset(input int wordNum);
      return cache_pkg::offset_t'(wordNum * 2);
   endfunction

   assign reqTag    = addr[`ADDR_W-1 -: `TAG_W];
   assign reqIndex  = addr[`OFFSET_W +: `INDEX_W];
   assign reqOffset = addr[`OFFSET_W-1:0];

   assign chosenTag   = chosenWay ? way1.tagOut  : way0.tagOut;
   assign chosenData  = chosenWay ? way1.dataOut : way0.dataOut;
   assign chosenValid = chosenWay ? way1.valid   : way0.valid;
   assign chosenDirty = chosenWay ? way1.dirty   : way0.dirty;
   assign anyHit      = way0.hit || way1.hit;

   // status outputs straight from the state
   assign done     = (state == cache_pkg::hitDone) || (state == cache_pkg::missDone);
   assign cacheHit = (state == cache_pkg::hitDone);
   assign stall    = !(done || (state == cache_pkg::idle));

   // read data from the hit way, after a fill the chosen way holds it
   assign dataOut = way0.hit ? way0.dataOut : (way1.hit ? way1.dataOut : chosenData);

   // ####################################################################
   // way choice
   // ####################################################################

   // in a done cycle the victim flips at this edge, so choose with the flipped value
   assign victimNext = done ? ~victimWay : victimWay;

   always_comb begin
      if (way0.hit)        choice = 1'b0;
      else if (way1.hit)   choice = 1'b1;
      else if (!way0.valid) choice = 1'b0;
      else if (!way1.valid) choice = 1'b1;
      else                 choice = victimNext;
   end

   // rd and wr together or neither is no request
   assign startState = (rd ^ wr) ? (rd ? cache_pkg::compareRead : cache_pkg::compareWrite)
                                 : cache_pkg::idle;

   // a miss on a dirty valid victim goes through write-back first
   assign lookupNext = anyHit ? cache_pkg::hitDone
                              : ((chosenValid && chosenDirty) ? cache_pkg::evict0
                                                              : cache_pkg::fill0);

   // ####################################################################
   // next state and datapath controls
   // ####################################################################

   always_comb begin
      nextState  = state;
      memRd      = 1'b0;
      memWr      = 1'b0;
      memTag     = reqTag;
      memOffset  = reqOffset;
      wayWrite   = 1'b0;
      wayCompare = 1'b0;
      wayOffset  = reqOffset;
      wayData    = dataIn;
      case (state)
         cache_pkg::idle, cache_pkg::hitDone, cache_pkg::missDone: begin
            nextState = startState;
         end
         cache_pkg::compareRead: begin
            wayCompare = 1'b1;
            nextState  = lookupNext;
         end
         cache_pkg::compareWrite: begin
            // lands only on a hit
            wayCompare = 1'b1;
            wayWrite   = 1'b1;
            nextState  = lookupNext;
         end
         // write-back uses the victim's stored tag
         cache_pkg::evict0, cache_pkg::evict1, cache_pkg::evict2, cache_pkg::evict3: begin
            memWr  = 1'b1;
            memTag = chosenTag;
            case (state)
               cache_pkg::evict0: memOffset = lineOffset(0);
               cache_pkg::evict1: memOffset = lineOffset(1);
               cache_pkg::evict2: memOffset = lineOffset(2);
               default:           memOffset = lineOffset(3);
            endcase
            wayOffset = memOffset;
            if (!mem.stall) begin
               case (state)
                  cache_pkg::evict0: nextState = cache_pkg::evict1;
                  cache_pkg::evict1: nextState = cache_pkg::evict2;
                  cache_pkg::evict2: nextState = cache_pkg::evict3;
                  default:           nextState = cache_pkg::fill0;
               endcase
            end
         end
         cache_pkg::fill0: begin
            memRd     = 1'b1;
            memOffset = lineOffset(0);
            if (!mem.stall) nextState = cache_pkg::fill1;
         end
         cache_pkg::fill1: begin
            memRd     = 1'b1;
            memOffset = lineOffset(1);
            if (!mem.stall) nextState = cache_pkg::fill2Write0;
         end
         // word 0 returns while word 2 is requested
         cache_pkg::fill2Write0: begin
            memRd     = 1'b1;
            memOffset = lineOffset(2);
            wayWrite  = 1'b1;
            wayOffset = lineOffset(0);
            wayData   = mem.dataOut;
            if (!mem.stall) nextState = cache_pkg::fill3Write1;
         end
         cache_pkg::fill3Write1: begin
            memRd     = 1'b1;
            memOffset = lineOffset(3);
            wayWrite  = 1'b1;
            wayOffset = lineOffset(1);
            wayData   = mem.dataOut;
            if (!mem.stall) nextState = cache_pkg::write2;
         end
         cache_pkg::write2: begin
            wayWrite  = 1'b1;
            wayOffset = lineOffset(2);
            wayData   = mem.dataOut;
            nextState = cache_pkg::write3;
         end
         cache_pkg::write3: begin
            wayWrite  = 1'b1;
            wayOffset = lineOffset(3);
            wayData   = mem.dataOut;
            nextState = (wr && !rd) ? cache_pkg::finalWrite : cache_pkg::missDone;
         end
         // the pending processor write, now a guaranteed hit
         cache_pkg::finalWrite: begin
            wayWrite   = 1'b1;
            wayCompare = 1'b1;
            nextState  = cache_pkg::missDone;
         end
         default: begin
            nextState = cache_pkg::idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state     <= cache_pkg::idle;
         chosenWay <= 1'b0;
         victimWay <= 1'b0;
      end else begin
         state <= nextState;
         // choice is fixed while a request is in progress
         if (!stall) chosenWay <= choice;
         if (done) victimWay <= ~victimWay;
      end
   end

   // ####################################################################
   // way and memory drive
   // ####################################################################

   // both ways look up every cycle, only the chosen one takes writes
   assign way0.enable  = !chosenWay;
   assign way0.write   = wayWrite;
   assign way0.compare = wayCompare;
   assign way0.tagIn   = reqTag;
   assign way0.index   = reqIndex;
   assign way0.offset  = wayOffset;
   assign way0.dataIn  = wayData;

   assign way1.enable  = chosenWay;
   assign way1.write   = wayWrite;
   assign way1.compare = wayCompare;
   assign way1.tagIn   = reqTag;
   assign way1.index   = reqIndex;
   assign way1.offset  = wayOffset;
   assign way1.dataIn  = wayData;

   assign mem.rd     = memRd;
   assign mem.wr     = memWr;
   assign mem.addr   = {memTag, reqIndex, memOffset};
   assign mem.dataIn = chosenData;

endmodule

`default_nettype wire

// ==== design/banked_memory.sv ====
/*
 * Banked main memory.
 * 32K words in four word-interleaved banks with busy counters and pipelined reads.
 */
`include "mem_system_cfg.svh"

`timescale 1ns/10ps

`default_nettype none

module banked_memory (
   input  logic    clk,
   input  logic    rstN,
   memIf.memory    port
);

   localparam int BankBits  = $clog2(`NUM_BANKS);
   localparam int RowBits   = `ADDR_W - 1 - BankBits;
   localparam int BankDepth = 2 ** RowBits;
   localparam int BusyW     = $clog2(`BANK_BUSY_CYCLES + 1);

   // ####################################################################
   // storage and address decode
   // ####################################################################

   // all words start at zero
   cache_pkg::word_t bankMem [`NUM_BANKS][BankDepth] = '{default: '0};

   logic [BankBits-1:0] bankSel;
   logic [RowBits-1:0]  rowSel;
   logic                accept;

   // remaining busy cycles per bank
   logic [BusyW-1:0]    busyCnt [`NUM_BANKS];

   // read data pipeline, last stage drives dataOut
   cache_pkg::word_t    rdPipe [`MEM_READ_LATENCY];

   // word address is addr[15:1], low two word bits pick the bank
   assign bankSel = port.addr[BankBits:1];
   assign rowSel  = port.addr[`ADDR_W-1:BankBits+1];

   // hold off while the addressed bank is still busy
   assign port.stall = (busyCnt[bankSel] != '0);
   assign accept     = (port.rd || port.wr) && !port.stall;

   // ####################################################################
   // bank occupancy
   // ####################################################################

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            busyCnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            if (accept && (bankSel == BankBits'(b))) begin
               busyCnt[b] <= BusyW'(`BANK_BUSY_CYCLES);
            end else if (busyCnt[b] != '0) begin
               busyCnt[b] <= busyCnt[b] - 1'b1;
            end
         end
      end
   end

   // ####################################################################
   // data path
   // ####################################################################

   // write lands at the accepting edge
   always_ff @(posedge clk) begin
      if (accept && port.wr) begin
         bankMem[bankSel][rowSel] <= port.dataIn;
      end
   end

   // stage 0 captures an accepted read, later stages just shift
   // so back to back reads overlap
   always_ff @(posedge clk) begin
      if (accept && port.rd) begin
         rdPipe[0] <= bankMem[bankSel][rowSel];
      end
      for (int s = 1; s < `MEM_READ_LATENCY; s++) begin
         rdPipe[s] <= rdPipe[s-1];
      end
   end

   assign port.dataOut = rdPipe[`MEM_READ_LATENCY-1];

endmodule

`default_nettype wire

// ==== design/cache_way.sv ====
/*
 * One cache way.
 * 256 sets of tag, valid, dirty and a four-word line with combinational lookup.
 */
`include "mem_system_cfg.svh"

`timescale 1ns/10ps

`default_nettype none

module cache_way (
   input  logic clk,
   input  logic rstN,
   wayIf.way    port
);

   localparam int NumSets  = 2 ** `INDEX_W;
   localparam int WordSelW = $clog2(`WORDS_PER_LINE);

   // tag and data arrays
   cache_pkg::tag_t  tagMem  [NumSets];
   cache_pkg::word_t dataMem [NumSets * `WORDS_PER_LINE];

   // per-set status bits
   logic [NumSets-1:0] validBits;
   logic [NumSets-1:0] dirtyBits;

   logic [`INDEX_W+WordSelW-1:0] wordAddr;
   logic                         tagMatch;
   logic                         doWrite;

   // word within the line comes from offset bits above the byte bit
   assign wordAddr = {port.index, port.offset[WordSelW:1]};

   // lookup
   assign tagMatch     = (tagMem[port.index] == port.tagIn);
   assign port.hit     = validBits[port.index] && tagMatch;
   assign port.valid   = validBits[port.index];
   assign port.dirty   = dirtyBits[port.index];
   assign port.tagOut  = tagMem[port.index];
   assign port.dataOut = dataMem[wordAddr];

   // compare write only lands on a hit
   // a fill write always lands
   assign doWrite = port.enable && port.write && (!port.compare || port.hit);

   always_ff @(posedge clk) begin
      if (doWrite) begin
         dataMem[wordAddr] <= port.dataIn;
         // fill brings in the new tag
         if (!port.compare) begin
            tagMem[port.index] <= port.tagIn;
         end
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else if (doWrite) begin
         if (port.compare) begin
            // processor write marks the line modified
            dirtyBits[port.index] <= 1'b1;
         end else begin
            // fresh line from memory is clean
            validBits[port.index] <= 1'b1;
            dirtyBits[port.index] <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/cache_ifs.sv ====
/*
 * Cache interfaces.
 * wayIf connects the controller to one way, memIf connects it to main memory.
 */
`timescale 1ns/10ps

`default_nettype none

interface wayIf;

   // request side, driven by the controller
   logic                 enable;
   logic                 write;
   logic                 compare;
   cache_pkg::tag_t      tagIn;
   cache_pkg::index_t    index;
   cache_pkg::offset_t   offset;
   cache_pkg::word_t     dataIn;

   // lookup results of the current index and offset
   cache_pkg::tag_t      tagOut;
   cache_pkg::word_t     dataOut;
   logic                 hit;
   logic                 dirty;
   logic                 valid;

   modport controller (
      output enable, write, compare, tagIn, index, offset, dataIn,
      input  tagOut, dataOut, hit, dirty, valid
   );

   modport way (
      input  enable, write, compare, tagIn, index, offset, dataIn,
      output tagOut, dataOut, hit, dirty, valid
   );

endinterface

interface memIf;

   // request is held while stall is high
   logic                 rd;
   logic                 wr;
   cache_pkg::addr_t     addr;
   cache_pkg::word_t     dataIn;
   cache_pkg::word_t     dataOut;
   logic                 stall;

   modport controller (
      output rd, wr, addr, dataIn,
      input  dataOut, stall
   );

   modport memory (
      input  rd, wr, addr, dataIn,
      output dataOut, stall
   );

endinterface

`default_nettype wire

// ==== design/cache_pkg.sv ====
/*
 * Cache package.
 * Controller state encoding and the address field and data word types.
 */
`include "mem_system_cfg.svh"

`default_nettype none

package cache_pkg;

   // data word and full byte address
   typedef logic [`WORD_W-1:0]   word_t;
   typedef logic [`ADDR_W-1:0]   addr_t;

   // address fields, tag on top and offset at the bottom
   typedef logic [`TAG_W-1:0]    tag_t;
   typedef logic [`INDEX_W-1:0]  index_t;
   typedef logic [`OFFSET_W-1:0] offset_t;

   // controller states
   typedef enum logic [4:0] {
      idle,
      compareRead,
      compareWrite,
      // dirty victim write-back, one word per state
      evict0,
      evict1,
      evict2,
      evict3,
      // line fill, memory reads run two states ahead of way writes
      fill0,
      fill1,
      fill2Write0,
      fill3Write1,
      write2,
      write3,
      finalWrite,
      missDone,
      hitDone
   } ctrlState_e;

endpackage

`default_nettype wire

// ==== design/mem_system_cfg.svh ====
/*
 * Memory system configuration.
 * Address and word widths, cache line geometry, bank count and main memory timing.
 */
`ifndef MEM_SYSTEM_CFG_SVH
`define MEM_SYSTEM_CFG_SVH

`default_nettype none

// byte address and data word
`define ADDR_W            16
`define WORD_W            16

// address split into tag, set index and byte offset
`define TAG_W             5
`define INDEX_W           8
`define OFFSET_W          3

// four words per line, so offset bit 0 is always zero
`define WORDS_PER_LINE    4

// main memory is word interleaved, bank picked by address bits 2:1
`define NUM_BANKS         4
`define MEM_READ_LATENCY  2
`define BANK_BUSY_CYCLES  4

`default_nettype wire

`endif
